//--- Bender.yml
package:
  name: pipeDebug

sources:
  # Design, in compile order
  - files:
      - hw/debugPkg.sv
      - hw/debugIf.sv
      - hw/aluPipe.sv
      - hw/perfCounters.sv
      - hw/debugSnapshot.sv
      - hw/debugWbSlave.sv
      - hw/debugTop.sv

  # Testbench
  - target: test
    files:
      - tb/debugTopTb.sv

//--- hw/aluPipe.sv
/*
 * Three-stage issue, execute and commit pipeline over a 4-entry register file.
 * The register file is written when an instruction leaves issue, so a following
 * instruction always sees the new value. Hold freezes every stage and the registers.
 */

`timescale 1ns/1ps

module aluPipe import debugPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   instValid,
    input  pcT     instPc,
    input  opT     instOp,
    input  regIdxT instDst,
    input  immT    instImm,
    input  logic   hold,
    debugIf.pipe   dbg
);

    // Issue stage
    logic   isValid;
    pcT     isPc;
    opT     isOp;
    regIdxT isDst;
    immT    isImm;

    // Execute and commit stages
    logic exValid;
    pcT   exPc;
    logic cmValid;
    pcT   cmPc;

    dataT regs [REG_NUM];
    dataT srcVal;
    dataT result;
    logic regWrite;
    pcT   lastPcQ;

    always_comb begin
        srcVal = regs[isDst];
        case (isOp)
            opAdd:   result = srcVal + dataT'(isImm);
            opSub:   result = srcVal - dataT'(isImm);
            opXor:   result = srcVal ^ dataT'(isImm);
            default: result = srcVal;
        endcase
        regWrite = isValid && (isOp != opNop);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            isValid <= 1'b0;
            exValid <= 1'b0;
            cmValid <= 1'b0;
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (!hold) begin
            isValid <= instValid;
            exValid <= isValid;
            cmValid <= exValid;
            if (regWrite) begin
                regs[isDst] <= result;
            end
        end
    end

    // Payload follows the valid flags
    always_ff @(posedge clk) begin
        if (!hold) begin
            isPc  <= instPc;
            isOp  <= instOp;
            isDst <= instDst;
            isImm <= instImm;
            exPc  <= isPc;
            cmPc  <= exPc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lastPcQ <= '0;
        end else if (cmValid && !hold) begin
            lastPcQ <= cmPc;
        end
    end

    assign dbg.isValid = isValid;
    assign dbg.isPc    = isPc;
    assign dbg.exValid = exValid;
    assign dbg.exPc    = exPc;
    assign dbg.cmValid = cmValid;
    assign dbg.cmPc    = cmPc;
    assign dbg.regs    = regs;
    assign dbg.hold    = hold;

    // Current commit shows up without waiting for the register
    assign dbg.lastCommittedPC = (cmValid && !hold) ? cmPc : lastPcQ;

endmodule : aluPipe

//--- hw/debugIf.sv
/*
 * Debug state from the pipeline side to the snapshot block.
 * The pipe and perf sides each drive their own fields; the debug side only reads.
 */

`timescale 1ns/1ps

interface debugIf import debugPkg::*; (
    input logic clk
);

    // Stage state
    logic isValid;
    pcT   isPc;
    logic exValid;
    pcT   exPc;
    logic cmValid;
    pcT   cmPc;

    dataT regs [REG_NUM];

    // Counters and control
    countT commitCount;
    countT holdCount;
    logic  hold;
    pcT    lastCommittedPC;

    modport pipe (
        input  clk,
        output isValid, isPc, exValid, exPc, cmValid, cmPc,
        output regs, hold, lastCommittedPC
    );

    modport perf (
        input  clk, cmValid, hold,
        output commitCount, holdCount
    );

    modport debug (
        input clk, isValid, isPc, exValid, exPc, cmValid, cmPc,
        input regs, commitCount, holdCount, hold, lastCommittedPC
    );

endinterface : debugIf

//--- hw/debugPkg.sv
/*
 * Shared types and constants for the pipeline debug tap.
 * The bus map is word addressed with 16 words; the unused top words read zero.
 * Immediates are zero-extended before use.
 */

package debugPkg;

    typedef logic [15:0] dataT;
    typedef logic [15:0] pcT;
    typedef logic [1:0]  regIdxT;
    typedef logic [7:0]  immT;
    typedef logic [15:0] countT;
    typedef logic [3:0]  wbAddrT;

    typedef enum logic [1:0] {
        opNop,
        opAdd,
        opSub,
        opXor
    } opT;

    localparam int REG_NUM = 4;

    // Register map, one 16-bit word per address
    localparam wbAddrT ADDR_STATUS   = 4'd0;
    localparam wbAddrT ADDR_IS_PC    = 4'd1;
    localparam wbAddrT ADDR_EX_PC    = 4'd2;
    localparam wbAddrT ADDR_CM_PC    = 4'd3;
    localparam wbAddrT ADDR_REG0     = 4'd4;
    localparam wbAddrT ADDR_REG3     = ADDR_REG0 + wbAddrT'(REG_NUM - 1);
    // Also the counter clear address on write
    localparam wbAddrT ADDR_COMMITS  = 4'd8;
    localparam wbAddrT ADDR_HOLDS    = 4'd9;
    localparam wbAddrT ADDR_LAST_PC  = 4'd10;

    // Status word layout
    localparam int STAT_IS_VALID = 0;
    localparam int STAT_EX_VALID = 1;
    localparam int STAT_CM_VALID = 2;
    localparam int STAT_HOLD     = 3;

endpackage : debugPkg

//--- hw/debugSnapshot.sv
/*
 * Registers the full debug state once per cycle, one cycle of latency on every field.
 * The data path has no reset. The last committed PC bypasses the register.
 */

`timescale 1ns/1ps

module debugSnapshot import debugPkg::*; (
    input  logic  clk,
    debugIf.debug dbg,
    output dataT  statusWord,
    output pcT    isPcQ,
    output pcT    exPcQ,
    output pcT    cmPcQ,
    output dataT  regsQ [REG_NUM],
    output countT commitCountQ,
    output countT holdCountQ,
    output pcT    lastCommittedPC
);

    dataT statusNext;

    always_comb begin
        statusNext                = '0;
        statusNext[STAT_IS_VALID] = dbg.isValid;
        statusNext[STAT_EX_VALID] = dbg.exValid;
        statusNext[STAT_CM_VALID] = dbg.cmValid;
        statusNext[STAT_HOLD]     = dbg.hold;
    end

    always_ff @(posedge clk) begin
        statusWord   <= statusNext;
        isPcQ        <= dbg.isPc;
        exPcQ        <= dbg.exPc;
        cmPcQ        <= dbg.cmPc;
        regsQ        <= dbg.regs;
        commitCountQ <= dbg.commitCount;
        holdCountQ   <= dbg.holdCount;
    end

    assign lastCommittedPC = dbg.lastCommittedPC;

endmodule : debugSnapshot

//--- hw/debugTop.sv
/*
 * Pipeline with its debug tap: counters, snapshot and a Wishbone classic read port.
 * Instructions arriving while hold is high are dropped.
 */

`timescale 1ns/1ps

module debugTop import debugPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   instValid,
    input  pcT     instPc,
    input  opT     instOp,
    input  regIdxT instDst,
    input  immT    instImm,
    input  logic   hold,
    input  logic   cyc,
    input  logic   stb,
    input  logic   we,
    input  wbAddrT adr,
    input  dataT   datW,
    output dataT   datR,
    output logic   ack,
    output pcT     lastCommittedPC
);

    debugIf dbgIf (.clk(clk));

    logic  clear;
    dataT  statusWord;
    pcT    isPcQ;
    pcT    exPcQ;
    pcT    cmPcQ;
    dataT  regsQ [REG_NUM];
    countT commitCountQ;
    countT holdCountQ;

    aluPipe pipe0 (
        .clk(clk), .rstN(rstN),
        .instValid(instValid), .instPc(instPc), .instOp(instOp),
        .instDst(instDst), .instImm(instImm), .hold(hold),
        .dbg(dbgIf.pipe)
    );

    perfCounters perf0 (.clk(clk), .rstN(rstN), .clear(clear), .dbg(dbgIf.perf));

    debugSnapshot snap0 (
        .clk(clk), .dbg(dbgIf.debug),
        .statusWord(statusWord), .isPcQ(isPcQ), .exPcQ(exPcQ), .cmPcQ(cmPcQ),
        .regsQ(regsQ), .commitCountQ(commitCountQ), .holdCountQ(holdCountQ),
        .lastCommittedPC(lastCommittedPC)
    );

    debugWbSlave wb0 (
        .clk(clk), .rstN(rstN),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW),
        .datR(datR), .ack(ack), .clear(clear),
        .statusWord(statusWord), .isPcQ(isPcQ), .exPcQ(exPcQ), .cmPcQ(cmPcQ),
        .regsQ(regsQ), .commitCountQ(commitCountQ), .holdCountQ(holdCountQ),
        .lastCommittedPC(lastCommittedPC)
    );

endmodule : debugTop

//--- hw/debugWbSlave.sv
/*
 * Wishbone classic slave over the debug snapshot, one 16-bit word per address.
 * Ack is a single registered pulse, so a held strobe is served every other cycle.
 * Only a write to the commit counter address has an effect; it clears both counters.
 */

`timescale 1ns/1ps

module debugWbSlave import debugPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   cyc,
    input  logic   stb,
    input  logic   we,
    input  wbAddrT adr,
    input  dataT   datW,
    output dataT   datR,
    output logic   ack,
    output logic   clear,
    input  dataT   statusWord,
    input  pcT     isPcQ,
    input  pcT     exPcQ,
    input  pcT     cmPcQ,
    input  dataT   regsQ [REG_NUM],
    input  countT  commitCountQ,
    input  countT  holdCountQ,
    input  pcT     lastCommittedPC
);

    logic start;
    dataT rdWord;

    // New request, answered on the next edge
    assign start = cyc && stb && !ack;

    // Write data is not stored, the address alone selects the action
    assign clear = start && we && (adr == ADDR_COMMITS);

    always_comb begin
        rdWord = '0;
        case (adr)
            ADDR_STATUS:  rdWord = statusWord;
            ADDR_IS_PC:   rdWord = isPcQ;
            ADDR_EX_PC:   rdWord = exPcQ;
            ADDR_CM_PC:   rdWord = cmPcQ;
            ADDR_COMMITS: rdWord = commitCountQ;
            ADDR_HOLDS:   rdWord = holdCountQ;
            ADDR_LAST_PC: rdWord = lastCommittedPC;
            default: begin
                if (adr >= ADDR_REG0 && adr <= ADDR_REG3) begin
                    rdWord = regsQ[regIdxT'(adr - ADDR_REG0)];
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack <= 1'b0;
        end else begin
            ack <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            datR <= we ? '0 : rdWord;
        end
    end

endmodule : debugWbSlave

//--- hw/perfCounters.sv
/*
 * Commit and hold-cycle counters, saturating at the maximum count.
 * Clear wins over counting on the same edge.
 */

`timescale 1ns/1ps

module perfCounters import debugPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic clear,
    debugIf.perf dbg
);

    countT commitCountQ;
    countT holdCountQ;
    logic  commitInc;
    logic  holdInc;

    // Every valid commit counts, nop included
    assign commitInc = dbg.cmValid && !dbg.hold && (commitCountQ != '1);
    assign holdInc   = dbg.hold && (holdCountQ != '1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            commitCountQ <= '0;
            holdCountQ   <= '0;
        end else if (clear) begin
            commitCountQ <= '0;
            holdCountQ   <= '0;
        end else begin
            if (commitInc) begin
                commitCountQ <= commitCountQ + 1'b1;
            end
            if (holdInc) begin
                holdCountQ <= holdCountQ + 1'b1;
            end
        end
    end

    assign dbg.commitCount = commitCountQ;
    assign dbg.holdCount   = holdCountQ;

endmodule : perfCounters

//--- pipeDebug.f
hw/debugPkg.sv
hw/debugIf.sv
hw/aluPipe.sv
hw/perfCounters.sv
hw/debugSnapshot.sv
hw/debugWbSlave.sv
hw/debugTop.sv
tb/debugTopTb.sv

//--- tb/debugTopTb.sv
/*
 * Table-driven testbench for debugTop with a reference model of the pipeline.
 * Bus reads happen only with the pipeline drained, since the snapshot lags the state.
 * Stops at the first error.
 */

`timescale 1ns/1ps

module debugTopTb import debugPkg::*; ();

    localparam int NUM_ROWS   = 16;
    localparam int DRAIN      = 4;
    localparam int NUM_XFERS  = 44;
    localparam int BUS_CYCLES = 4;
    localparam int ACK_WAIT   = 8;

    typedef struct packed {
        pcT         pc;
        opT         op;
        regIdxT     dst;
        immT        imm;
        logic [3:0] holds;
    } rowT;

    logic clk, rstN, instValid, hold, cyc, stb, we, ack;
    pcT instPc, lastCommittedPC;
    opT instOp;
    regIdxT instDst;
    immT instImm;
    wbAddrT adr;
    dataT datW, datR;

    rowT   stim [NUM_ROWS];
    dataT  modelRegs [REG_NUM];
    countT modelCommits, modelHolds;
    pcT    modelLastPc;
    int    cycles = 0;
    int    cycleLimit = 0;
    int    xfers = 0;
    int    ackPulses = 0;

    debugTop dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit != 0 && cycles > cycleLimit) begin
            $display("Timeout: run took more than %0d cycles", cycleLimit);
            stopRun();
        end
    end

    always @(negedge clk) begin
        if (ack === 1'b1) ackPulses++;
    end

    task automatic stopRun();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input string name, input dataT got, input dataT exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    // One classic cycle; ack is sampled on the falling edge
    task automatic busXfer(input logic wr, input wbAddrT a, input dataT w, output dataT d);
        int waited;
        waited = 0;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= wr;
        adr <= a;
        datW <= w;
        @(negedge clk);
        while (ack !== 1'b1 && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (ack === 1'b1) else begin
            $display("No ack from the bus slave for address %0d", a);
            stopRun();
        end
        d = datR;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        @(negedge clk);
        xfers++;
        assert (ack === 1'b0 && ackPulses == xfers) else begin
            $display("Ack was not a single pulse: %0d pulses in %0d transfers", ackPulses, xfers);
            stopRun();
        end
    endtask

    task automatic readExpect(input wbAddrT a, input dataT exp, input string name);
        dataT rd;
        busXfer(1'b0, a, '0, rd);
        checkWord(name, rd, exp);
    endtask

    task automatic addRow(input int i, input pcT pc, input opT op, input regIdxT dst,
                          input immT imm, input int holds);
        stim[i].pc = pc;
        stim[i].op = op;
        stim[i].dst = dst;
        stim[i].imm = imm;
        stim[i].holds = holds[3:0];
    endtask

    function automatic dataT aluRef(input opT op, input dataT a, input immT imm);
        case (op)
            opAdd:   return a + {8'h00, imm};
            opSub:   return a - {8'h00, imm};
            opXor:   return a ^ {8'h00, imm};
            default: return a;
        endcase
    endfunction

    task automatic runTable();
        for (int i = 0; i < NUM_ROWS; i++) begin
            for (int h = 0; h < stim[i].holds; h++) begin
                @(posedge clk);
                hold <= 1'b1;
                instValid <= 1'b0;
            end
            @(posedge clk);
            hold <= 1'b0;
            instValid <= 1'b1;
            instPc <= stim[i].pc;
            instOp <= stim[i].op;
            instDst <= stim[i].dst;
            instImm <= stim[i].imm;
            modelRegs[stim[i].dst] = aluRef(stim[i].op, modelRegs[stim[i].dst], stim[i].imm);
            modelCommits++;
            modelHolds += stim[i].holds;
            modelLastPc = stim[i].pc;
        end
        @(posedge clk);
        instValid <= 1'b0;
        repeat (DRAIN) @(posedge clk);
    endtask

    task automatic checkState(input string tag);
        for (int r = 0; r < REG_NUM; r++) begin
            readExpect(ADDR_REG0 + wbAddrT'(r), modelRegs[r], $sformatf("%s reg%0d", tag, r));
        end
        readExpect(ADDR_COMMITS, modelCommits, {tag, " commit count"});
        readExpect(ADDR_HOLDS, modelHolds, {tag, " hold count"});
        readExpect(ADDR_LAST_PC, modelLastPc, {tag, " last PC word"});
        @(negedge clk);
        checkWord({tag, " lastCommittedPC port"}, lastCommittedPC, modelLastPc);
    endtask

    initial begin
        dataT rd;
        int holdSum;
        void'($urandom(12045));
        rstN <= 1'b0;
        instValid <= 1'b0;
        instPc <= '0;
        instOp <= opNop;
        instDst <= '0;
        instImm <= '0;
        hold <= 1'b0;
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        adr <= '0;
        datW <= '0;

        // Back-to-back writes to r0 and r2, nops and holds mixed in
        addRow(0, 16'h0100, opAdd, 2'd0, 8'h12, 0);
        addRow(1, 16'h0102, opAdd, 2'd0, 8'h34, 0);
        addRow(2, 16'h0104, opSub, 2'd1, 8'h05, 2);
        addRow(3, 16'h0106, opXor, 2'd2, 8'hff, 0);
        addRow(4, 16'h0108, opNop, 2'd3, 8'h77, 0);
        addRow(5, 16'h010a, opAdd, 2'd3, 8'h80, 1);
        addRow(6, 16'h010c, opSub, 2'd0, 8'h10, 0);
        addRow(7, 16'h010e, opXor, 2'd0, 8'h0f, 0);
        addRow(8, 16'h0110, opAdd, 2'd1, 8'h20, 3);
        addRow(9, 16'h0112, opNop, 2'd1, 8'haa, 0);
        addRow(10, 16'h0114, opSub, 2'd2, 8'h01, 0);
        addRow(11, 16'h0116, opXor, 2'd3, 8'h5a, 1);
        addRow(12, 16'h0118, opAdd, 2'd2, 8'h7f, 0);
        addRow(13, 16'h011a, opAdd, 2'd2, 8'h7f, 0);
        addRow(14, 16'h011c, opSub, 2'd3, 8'hc3, 2);
        addRow(15, 16'h011e, opXor, 2'd1, 8'h3c, 0);

        holdSum = 0;
        for (int i = 0; i < NUM_ROWS; i++) holdSum += stim[i].holds;
        cycleLimit = 2 * (NUM_ROWS + holdSum + DRAIN + 1) + NUM_XFERS * BUS_CYCLES + 200;
        for (int r = 0; r < REG_NUM; r++) modelRegs[r] = '0;
        modelCommits = '0;
        modelHolds = '0;
        modelLastPc = '0;

        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        for (int a = 0; a < 16; a++) begin
            readExpect(wbAddrT'(a), '0, $sformatf("word %0d after reset", a));
        end
        @(negedge clk);
        checkWord("lastCommittedPC port after reset", lastCommittedPC, '0);

        runTable();
        checkState("pass 1");

        // Status taken with hold high and the pipeline empty
        @(posedge clk);
        hold <= 1'b1;
        repeat (2) @(posedge clk);
        readExpect(ADDR_STATUS, dataT'(1) << STAT_HOLD, "status under hold");
        @(posedge clk);
        hold <= 1'b0;

        busXfer(1'b1, ADDR_COMMITS, 16'hffff, rd);
        modelCommits = '0;
        modelHolds = '0;
        repeat (2) @(posedge clk);
        checkState("after clear");
        for (int a = 11; a < 16; a++) begin
            readExpect(wbAddrT'(a), '0, $sformatf("unused word %0d", a));
        end

        // Second pass on new addresses so the last PC has to move
        for (int i = 0; i < NUM_ROWS; i++) begin
            stim[i].imm = immT'($urandom);
            stim[i].pc = stim[i].pc + 16'h1000;
        end
        runTable();
        checkState("pass 2");

        $display("Simulation PASSED");
        $finish;
    end

endmodule : debugTopTb
